// File: Makefile
TOP := tb_wb_hyperram_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: hb_addr_decode.sv
`timescale 1ns/10ps
`include "hb_bridge_macros.svh"

module hb_addr_decode (
	input  logic                       wbs_stb_i,
	input  logic                       wbs_cyc_i,
	input  logic [31:0]                wbs_adr_i,
	output hb_bridge_pkg::hb_region_e  region_o,
	output logic [31:0]                sub_adr_o,
	output hb_bridge_pkg::hb_csr_idx_e csr_idx_o
);

	logic active;
	logic ram_hit;
	logic reg_hit;
	logic csr_hit;

	assign active  = wbs_stb_i && wbs_cyc_i;
	assign ram_hit = ((wbs_adr_i & `HB_RAM_MASK) == `HB_BASE_ADDR);
	assign reg_hit = ((wbs_adr_i & `HB_WIN_MASK) == (`HB_BASE_ADDR + `HB_REG_OFFSET));
	assign csr_hit = ((wbs_adr_i & `HB_WIN_MASK) == (`HB_BASE_ADDR + `HB_CSR_OFFSET));

	// region and offset inside it
	always_comb begin
		region_o  = hb_bridge_pkg::hb_region_none;
		sub_adr_o = 32'h0000_0000;
		if (active) begin
			if (ram_hit) begin
				region_o  = hb_bridge_pkg::hb_region_ram;
				sub_adr_o = wbs_adr_i & ~`HB_RAM_MASK;
			end else if (reg_hit) begin
				region_o  = hb_bridge_pkg::hb_region_reg;
				sub_adr_o = wbs_adr_i & ~`HB_WIN_MASK;
			end else if (csr_hit) begin
				region_o  = hb_bridge_pkg::hb_region_csr;
				sub_adr_o = wbs_adr_i & ~`HB_WIN_MASK;
			end
		end
	end

	// control register index, exact word match only
	always_comb begin
		csr_idx_o = hb_bridge_pkg::hb_idx_unmapped;
		if (region_o == hb_bridge_pkg::hb_region_csr) begin
			case (sub_adr_o)
				`HB_CSR_LATENCY:    csr_idx_o = hb_bridge_pkg::hb_idx_latency;
				`HB_CSR_TPRE_TPOST: csr_idx_o = hb_bridge_pkg::hb_idx_tpre_tpost;
				`HB_CSR_TCSH:       csr_idx_o = hb_bridge_pkg::hb_idx_tcsh;
				`HB_CSR_TRMAX:      csr_idx_o = hb_bridge_pkg::hb_idx_trmax;
				`HB_CSR_STATUS:     csr_idx_o = hb_bridge_pkg::hb_idx_status;
				default:            csr_idx_o = hb_bridge_pkg::hb_idx_unmapped;
			endcase
		end
	end

endmodule

// File: hb_bridge_macros.svh
`ifndef HB_BRIDGE_MACROS_SVH
`define HB_BRIDGE_MACROS_SVH

// base of the whole decoded space, RAM sits first
`define HB_BASE_ADDR      32'h3000_0000

// 8 MB RAM region
`define HB_RAM_MASK       32'hff80_0000

// register-space and control windows are 64 KB apart
`define HB_WIN_MASK       32'hffff_0000

// window offsets from the base
`define HB_REG_OFFSET     32'h0080_0000
`define HB_CSR_OFFSET     32'h0081_0000

// byte offsets inside the control window
`define HB_CSR_LATENCY    32'h0000_0000
`define HB_CSR_TPRE_TPOST 32'h0000_0004
`define HB_CSR_TCSH       32'h0000_0008
`define HB_CSR_TRMAX      32'h0000_000c
`define HB_CSR_STATUS     32'h0000_0010

// shadow register reset values
// latency is {fixed, double, tacc}
`define HB_DEF_LATENCY    6'h36
// tpre in the upper nibble, tpost in the lower
`define HB_DEF_TPRE_TPOST 8'h44
`define HB_DEF_TCSH       4'h4
`define HB_DEF_TRMAX      5'h14

`endif

// File: hb_bridge_pkg.sv
package hb_bridge_pkg;

	// decoded bus region
	typedef enum logic [1:0] {
		hb_region_none,
		hb_region_ram,
		hb_region_reg,
		hb_region_csr
	} hb_region_e;

	// control window register index
	typedef enum logic [2:0] {
		hb_idx_latency,
		hb_idx_tpre_tpost,
		hb_idx_tcsh,
		hb_idx_trmax,
		hb_idx_status,
		hb_idx_unmapped
	} hb_csr_idx_e;

	// timing parameters for the controller core
	typedef struct packed {
		logic       fixed_latency;
		logic       double_latency;
		logic [3:0] tacc;
		logic [3:0] tpre;
		logic [3:0] tpost;
		logic [3:0] tcsh;
		logic [4:0] trmax;
	} hb_timing_t;

	typedef struct packed {
		logic [25:0] rsvd;
		logic        fixed_latency;
		logic        double_latency;
		logic [3:0]  tacc;
	} hb_csr_latency_t;

	typedef struct packed {
		logic [23:0] rsvd;
		logic [3:0]  tpre;
		logic [3:0]  tpost;
	} hb_csr_tpre_tpost_t;

	typedef struct packed {
		logic [27:0] rsvd;
		logic [3:0]  tcsh;
	} hb_csr_tcsh_t;

	typedef struct packed {
		logic [26:0] rsvd;
		logic [4:0]  trmax;
	} hb_csr_trmax_t;

	typedef struct packed {
		logic [30:0] rsvd;
		logic        read_timeout;
	} hb_csr_status_t;

	// one bus word seen either raw or as a register layout
	typedef union packed {
		logic [31:0]        raw;
		hb_csr_latency_t    latency;
		hb_csr_tpre_tpost_t tpre_tpost;
		hb_csr_tcsh_t       tcsh;
		hb_csr_trmax_t      trmax;
		hb_csr_status_t     status;
	} hb_csr_word_u;

	// request to the core, addr is a half-word address
	typedef struct packed {
		logic        valid;
		logic        we;
		logic        regspace;
		logic [31:0] addr;
		logic [3:0]  sel;
		logic [31:0] data;
	} hb_req_t;

	typedef struct packed {
		logic        ready;
		logic        read_timeout;
		logic [31:0] data;
	} hb_rsp_t;

endpackage

// File: hb_bus_response.sv
`timescale 1ns/10ps

module hb_bus_response (
	input  logic                      wb_clk_i,
	input  logic                      rst_i,
	input  logic                      wbs_we_i,
	input  logic [3:0]                wbs_sel_i,
	input  logic [31:0]               wbs_dat_i,
	input  hb_bridge_pkg::hb_region_e region_i,
	input  logic [31:0]               sub_adr_i,
	input  logic                      csr_ack_i,
	input  logic [31:0]               csr_rdata_i,
	input  hb_bridge_pkg::hb_rsp_t    hb_rsp_i,
	output hb_bridge_pkg::hb_req_t    hb_req_o,
	output logic                      wbs_ack_o,
	output logic [31:0]               wbs_dat_o
);

	logic mem_access;
	logic mem_seen_q;

	assign mem_access = (region_i == hb_bridge_pkg::hb_region_ram) ||
		(region_i == hb_bridge_pkg::hb_region_reg);

	// ready is ignored in the first cycle of an access
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			mem_seen_q <= 1'b0;
		end else begin
			mem_seen_q <= mem_access;
		end
	end

	// request level held for the whole access
	always_comb begin
		hb_req_o.valid    = mem_access;
		hb_req_o.we       = wbs_we_i;
		hb_req_o.regspace = (region_i == hb_bridge_pkg::hb_region_reg);
		hb_req_o.addr     = {1'b0, sub_adr_i[31:1]};
		hb_req_o.sel      = wbs_sel_i;
		hb_req_o.data     = wbs_dat_i;
	end

	always_comb begin
		case (region_i)
			hb_bridge_pkg::hb_region_ram,
			hb_bridge_pkg::hb_region_reg: wbs_ack_o = mem_seen_q && hb_rsp_i.ready;
			hb_bridge_pkg::hb_region_csr: wbs_ack_o = csr_ack_i;
			default:                      wbs_ack_o = 1'b0;
		endcase
	end

	// writes and misses read as zero
	always_comb begin
		if (wbs_we_i || region_i == hb_bridge_pkg::hb_region_none) begin
			wbs_dat_o = 32'h0000_0000;
		end else if (region_i == hb_bridge_pkg::hb_region_csr) begin
			wbs_dat_o = csr_rdata_i;
		end else begin
			wbs_dat_o = hb_rsp_i.data;
		end
	end

	// ack only ends an access already decoded in the same region a cycle earlier
	ack_needs_region: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		wbs_ack_o |-> ($past(region_i) == region_i));

endmodule

// File: hb_csr_file.sv
`timescale 1ns/10ps
`include "hb_bridge_macros.svh"

module hb_csr_file (
	input  logic                       wb_clk_i,
	input  logic                       rst_i,
	input  logic                       wbs_we_i,
	input  logic [3:0]                 wbs_sel_i,
	input  logic [31:0]                wbs_dat_i,
	input  hb_bridge_pkg::hb_region_e  region_i,
	input  hb_bridge_pkg::hb_csr_idx_e csr_idx_i,
	input  logic                       read_timeout_i,
	output hb_bridge_pkg::hb_timing_t  timing_o,
	output logic                       csr_ack_o,
	output logic [31:0]                csr_rdata_o
);

	logic                        csr_access;
	logic                        csr_seen_q;
	logic                        csr_ack_q;
	logic                        csr_wr_en;
	hb_bridge_pkg::hb_csr_word_u wr_word;
	hb_bridge_pkg::hb_csr_word_u rd_word;
	hb_bridge_pkg::hb_timing_t   timing_q;

	assign csr_access = (region_i == hb_bridge_pkg::hb_region_csr);
	assign wr_word    = wbs_dat_i;

	// only the first cycle of an access writes, byte 0 must be selected
	assign csr_wr_en = csr_access && !csr_seen_q && wbs_we_i && wbs_sel_i[0];

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			csr_seen_q <= 1'b0;
			csr_ack_q  <= 1'b0;
		end else begin
			csr_seen_q <= csr_access;
			csr_ack_q  <= csr_access && (csr_idx_i != hb_bridge_pkg::hb_idx_unmapped);
		end
	end

	// ack one cycle late and dropped with the strobe
	assign csr_ack_o = csr_ack_q && csr_access;

	// timing shadow registers
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			{timing_q.fixed_latency, timing_q.double_latency, timing_q.tacc} <= `HB_DEF_LATENCY;
			{timing_q.tpre, timing_q.tpost} <= `HB_DEF_TPRE_TPOST;
			timing_q.tcsh  <= `HB_DEF_TCSH;
			timing_q.trmax <= `HB_DEF_TRMAX;
		end else if (csr_wr_en) begin
			case (csr_idx_i)
				hb_bridge_pkg::hb_idx_latency: begin
					timing_q.fixed_latency  <= wr_word.latency.fixed_latency;
					timing_q.double_latency <= wr_word.latency.double_latency;
					timing_q.tacc           <= wr_word.latency.tacc;
				end
				hb_bridge_pkg::hb_idx_tpre_tpost: begin
					timing_q.tpre  <= wr_word.tpre_tpost.tpre;
					timing_q.tpost <= wr_word.tpre_tpost.tpost;
				end
				hb_bridge_pkg::hb_idx_tcsh:  timing_q.tcsh  <= wr_word.tcsh.tcsh;
				hb_bridge_pkg::hb_idx_trmax: timing_q.trmax <= wr_word.trmax.trmax;
				// status is read only
				default: begin
				end
			endcase
		end
	end

	assign timing_o = timing_q;

	// readback in the same layouts
	always_comb begin
		rd_word = '0;
		case (csr_idx_i)
			hb_bridge_pkg::hb_idx_latency: begin
				rd_word.latency.fixed_latency  = timing_q.fixed_latency;
				rd_word.latency.double_latency = timing_q.double_latency;
				rd_word.latency.tacc           = timing_q.tacc;
			end
			hb_bridge_pkg::hb_idx_tpre_tpost: begin
				rd_word.tpre_tpost.tpre  = timing_q.tpre;
				rd_word.tpre_tpost.tpost = timing_q.tpost;
			end
			hb_bridge_pkg::hb_idx_tcsh:   rd_word.tcsh.tcsh = timing_q.tcsh;
			hb_bridge_pkg::hb_idx_trmax:  rd_word.trmax.trmax = timing_q.trmax;
			hb_bridge_pkg::hb_idx_status: rd_word.status.read_timeout = read_timeout_i;
			default:                      rd_word = '0;
		endcase
	end

	assign csr_rdata_o = rd_word.raw;

	// timing only moves after a control write on the bus
	shadow_write_only: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		$changed(timing_q) |-> $past(csr_access && wbs_we_i));

endmodule

// File: src.f
+incdir+.
hb_bridge_pkg.sv
hb_addr_decode.sv
hb_csr_file.sv
hb_bus_response.sv
wb_hyperram_bridge.sv
tb_hyperram_core_model.sv
tb_wb_hyperram_bridge.sv

// File: tb_hyperram_core_model.sv
`timescale 1ns/10ps

module tb_hyperram_core_model (
	input  logic                   wb_clk_i,
	input  logic                   rst_i,
	input  hb_bridge_pkg::hb_req_t req_i,
	input  logic                   timeout_level_i,
	output hb_bridge_pkg::hb_rsp_t rsp_o
);

	logic [31:0] mem [0:63];
	logic [31:0] rd_data_q;
	logic        ready_q;
	logic        busy_q;
	logic        done_q;
	logic [5:0]  idx;
	int          delay_q;
	int          seed = 41;

	// addr is a half-word address, so word index starts at bit 1
	assign idx = req_i.addr[6:1];

	always @(posedge wb_clk_i) begin
		if (rst_i) begin
			ready_q   <= 1'b0;
			busy_q    <= 1'b0;
			done_q    <= 1'b0;
			delay_q   <= 0;
			rd_data_q <= 32'h0000_0000;
			for (int i = 0; i < 64; i++) begin
				mem[i] <= 32'h5a5a_0000 ^ i;
			end
		end else if (!req_i.valid) begin
			ready_q <= 1'b0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
		end else if (ready_q) begin
			// one ready pulse, then wait for the request to drop
			ready_q <= 1'b0;
			done_q  <= 1'b1;
		end else if (!busy_q && !done_q) begin
			busy_q  <= 1'b1;
			delay_q <= 1 + ($unsigned($random(seed)) % 6);
		end else if (busy_q) begin
			if (delay_q <= 1) begin
				busy_q  <= 1'b0;
				ready_q <= 1'b1;
				if (req_i.we) begin
					for (int b = 0; b < 4; b++) begin
						if (req_i.sel[b]) begin
							mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
						end
					end
				end else begin
					rd_data_q <= mem[idx];
				end
			end else begin
				delay_q <= delay_q - 1;
			end
		end
	end

	always_comb begin
		rsp_o.ready        = ready_q;
		rsp_o.read_timeout = timeout_level_i;
		rsp_o.data         = rd_data_q;
	end

endmodule

// File: tb_wb_hyperram_bridge.sv
`timescale 1ns/10ps
`include "hb_bridge_macros.svh"

module tb_wb_hyperram_bridge;

	// longest access is six cycles of core delay plus the handshake
	localparam int NUM_ACCESSES  = 44;
	localparam int MAX_ACCESS    = 10;
	localparam int TIMEOUT_LIMIT = NUM_ACCESSES * MAX_ACCESS + 100;
	localparam logic [31:0] CSR_BASE = `HB_BASE_ADDR + `HB_CSR_OFFSET;

	logic                      wb_clk_i;
	logic                      rst_i;
	logic                      wbs_stb_i;
	logic                      wbs_cyc_i;
	logic                      wbs_we_i;
	logic [3:0]                wbs_sel_i;
	logic [31:0]               wbs_adr_i;
	logic [31:0]               wbs_dat_i;
	logic                      wbs_ack_o;
	logic [31:0]               wbs_dat_o;
	hb_bridge_pkg::hb_req_t    hb_req_o;
	hb_bridge_pkg::hb_timing_t hb_timing_o;
	hb_bridge_pkg::hb_rsp_t    hb_rsp_i;
	logic                      timeout_level;
	hb_bridge_pkg::hb_req_t    last_req;
	hb_bridge_pkg::hb_timing_t exp_timing;
	int                        ack_wait;
	int                        seed = 41;

	wb_hyperram_bridge wb_hyperram_bridge_i (
		.wb_clk_i    (wb_clk_i),
		.rst_i       (rst_i),
		.wbs_stb_i   (wbs_stb_i),
		.wbs_cyc_i   (wbs_cyc_i),
		.wbs_we_i    (wbs_we_i),
		.wbs_sel_i   (wbs_sel_i),
		.wbs_adr_i   (wbs_adr_i),
		.wbs_dat_i   (wbs_dat_i),
		.wbs_ack_o   (wbs_ack_o),
		.wbs_dat_o   (wbs_dat_o),
		.hb_req_o    (hb_req_o),
		.hb_timing_o (hb_timing_o),
		.hb_rsp_i    (hb_rsp_i)
	);

	tb_hyperram_core_model core_model_i (
		.wb_clk_i        (wb_clk_i),
		.rst_i           (rst_i),
		.req_i           (hb_req_o),
		.timeout_level_i (timeout_level),
		.rsp_o           (hb_rsp_i)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #20 wb_clk_i = ~wb_clk_i;
	end

	// global watchdog
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_LIMIT) begin
			@(posedge wb_clk_i);
			cycles++;
		end
		$display("Result: FAILED");
		$fatal(1, "timeout, a bus access was never acknowledged");
	end

	task automatic check_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("error %s expected %h got %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "word mismatch on %s", name);
		end
	endtask

	task automatic check_timing(input string name, input hb_bridge_pkg::hb_timing_t exp,
		input hb_bridge_pkg::hb_timing_t act);
		if (act !== exp) begin
			$display("error %s expected %h got %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "timing mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s expected %h got %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "flag mismatch on %s", name);
		end
	endtask

	// drive on the rising edge, sample on the falling edge
	task automatic bus_access(input logic we, input logic [31:0] adr,
		input logic [31:0] dat, input logic [3:0] sel, output logic [31:0] rdata);
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b1;
		wbs_cyc_i <= 1'b1;
		wbs_we_i  <= we;
		wbs_adr_i <= adr;
		wbs_dat_i <= dat;
		wbs_sel_i <= sel;
		ack_wait = 0;
		@(negedge wb_clk_i);
		while (!wbs_ack_o) begin
			@(negedge wb_clk_i);
			ack_wait++;
		end
		rdata    = wbs_dat_o;
		last_req = hb_req_o;
		// memory ack must never run ahead of the core
		if (hb_req_o.valid) begin
			check_flag("hb_rsp_i.ready", 1'b1, hb_rsp_i.ready);
		end
		if (we) begin
			check_word("wbs_dat_o", 32'h0000_0000, wbs_dat_o);
		end
		@(posedge wb_clk_i);
		wbs_stb_i <= 1'b0;
		wbs_cyc_i <= 1'b0;
		wbs_we_i  <= 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(1'b1, adr, dat, sel, unused);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdata);
		bus_access(1'b0, adr, 32'h0000_0000, 4'hf, rdata);
	endtask

	task automatic check_csr_readback();
		hb_bridge_pkg::hb_csr_word_u w;
		logic [31:0]                 rd;
		check_timing("hb_timing_o", exp_timing, hb_timing_o);
		wb_read(CSR_BASE + `HB_CSR_LATENCY, rd);
		w = '0;
		w.latency.fixed_latency  = exp_timing.fixed_latency;
		w.latency.double_latency = exp_timing.double_latency;
		w.latency.tacc           = exp_timing.tacc;
		check_word("latency readback", w.raw, rd);
		wb_read(CSR_BASE + `HB_CSR_TPRE_TPOST, rd);
		w = '0;
		w.tpre_tpost.tpre  = exp_timing.tpre;
		w.tpre_tpost.tpost = exp_timing.tpost;
		check_word("tpre_tpost readback", w.raw, rd);
		wb_read(CSR_BASE + `HB_CSR_TCSH, rd);
		w = '0;
		w.tcsh.tcsh = exp_timing.tcsh;
		check_word("tcsh readback", w.raw, rd);
		wb_read(CSR_BASE + `HB_CSR_TRMAX, rd);
		w = '0;
		w.trmax.trmax = exp_timing.trmax;
		check_word("trmax readback", w.raw, rd);
	endtask

	task automatic test_reset_defaults();
		{exp_timing.fixed_latency, exp_timing.double_latency, exp_timing.tacc} = `HB_DEF_LATENCY;
		{exp_timing.tpre, exp_timing.tpost} = `HB_DEF_TPRE_TPOST;
		exp_timing.tcsh  = `HB_DEF_TCSH;
		exp_timing.trmax = `HB_DEF_TRMAX;
		check_csr_readback();
	endtask

	task automatic test_csr_write();
		wb_write(CSR_BASE + `HB_CSR_LATENCY, 32'h0000_0025, 4'h1);
		check_word("wbs_ack_o delay", 32'd1, ack_wait);
		exp_timing.fixed_latency  = 1'b1;
		exp_timing.double_latency = 1'b0;
		exp_timing.tacc           = 4'h5;
		wb_write(CSR_BASE + `HB_CSR_TPRE_TPOST, 32'h0000_00a3, 4'hf);
		check_word("wbs_ack_o delay", 32'd1, ack_wait);
		exp_timing.tpre  = 4'ha;
		exp_timing.tpost = 4'h3;
		check_csr_readback();
		// byte 0 not selected, so tcsh keeps its value
		wb_write(CSR_BASE + `HB_CSR_TCSH, 32'h0000_000b, 4'he);
		check_word("wbs_ack_o delay", 32'd1, ack_wait);
		wb_write(CSR_BASE + `HB_CSR_TRMAX, 32'h0000_0009, 4'h1);
		check_word("wbs_ack_o delay", 32'd1, ack_wait);
		exp_timing.trmax = 5'h09;
		check_csr_readback();
	endtask

	task automatic test_status_word();
		hb_bridge_pkg::hb_csr_word_u w;
		logic [31:0]                 rd;
		for (int lvl = 1; lvl >= 0; lvl--) begin
			@(posedge wb_clk_i);
			timeout_level <= lvl[0];
			wb_read(CSR_BASE + `HB_CSR_STATUS, rd);
			w = '0;
			w.status.read_timeout = lvl[0];
			check_word("status readback", w.raw, rd);
		end
	endtask

	task automatic test_ram_roundtrip();
		logic [31:0] adr;
		logic [31:0] full;
		logic [31:0] part;
		logic [31:0] expect_word;
		logic [31:0] rd;
		logic [3:0]  sel;
		for (int i = 0; i < 8; i++) begin
			adr  = `HB_BASE_ADDR + ($random(seed) & 32'h007f_fffc);
			full = $random(seed);
			part = $random(seed);
			sel  = 4'($random(seed));
			wb_write(adr, full, 4'hf);
			wb_write(adr, part, sel);
			expect_word = full;
			for (int b = 0; b < 4; b++) begin
				if (sel[b]) begin
					expect_word[8*b +: 8] = part[8*b +: 8];
				end
			end
			wb_read(adr, rd);
			check_flag("hb_req_o.regspace", 1'b0, last_req.regspace);
			check_word("hb_req_o.addr", (adr - `HB_BASE_ADDR) >> 1, last_req.addr);
			check_word("ram readback", expect_word, rd);
		end
	endtask

	task automatic test_regspace();
		logic [31:0] adr;
		logic [31:0] rd;
		adr = `HB_BASE_ADDR + `HB_REG_OFFSET + 32'h0000_0008;
		wb_write(adr, 32'hc0de_0102, 4'hf);
		check_flag("hb_req_o.regspace", 1'b1, last_req.regspace);
		wb_read(adr, rd);
		check_flag("hb_req_o.regspace", 1'b1, last_req.regspace);
		check_word("hb_req_o.addr", 32'h0000_0004, last_req.addr);
		check_word("regspace readback", 32'hc0de_0102, rd);
	endtask

	initial begin
		rst_i         = 1'b1;
		wbs_stb_i     = 1'b0;
		wbs_cyc_i     = 1'b0;
		wbs_we_i      = 1'b0;
		wbs_sel_i     = 4'h0;
		wbs_adr_i     = 32'h0000_0000;
		wbs_dat_i     = 32'h0000_0000;
		timeout_level = 1'b0;
		repeat (4) @(posedge wb_clk_i);
		rst_i <= 1'b0;
		test_reset_defaults();
		test_csr_write();
		test_status_word();
		test_ram_roundtrip();
		test_regspace();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: wb_hyperram_bridge.sv
`timescale 1ns/10ps

module wb_hyperram_bridge (
	input  logic                      wb_clk_i,
	input  logic                      rst_i,
	input  logic                      wbs_stb_i,
	input  logic                      wbs_cyc_i,
	input  logic                      wbs_we_i,
	input  logic [3:0]                wbs_sel_i,
	input  logic [31:0]               wbs_adr_i,
	input  logic [31:0]               wbs_dat_i,
	output logic                      wbs_ack_o,
	output logic [31:0]               wbs_dat_o,
	output hb_bridge_pkg::hb_req_t    hb_req_o,
	output hb_bridge_pkg::hb_timing_t hb_timing_o,
	input  hb_bridge_pkg::hb_rsp_t    hb_rsp_i
);

	hb_bridge_pkg::hb_region_e  region;
	hb_bridge_pkg::hb_csr_idx_e csr_idx;
	logic [31:0]                sub_adr;
	logic                       csr_ack;
	logic [31:0]                csr_rdata;

	hb_addr_decode hb_addr_decode_i (
		.wbs_stb_i (wbs_stb_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_adr_i (wbs_adr_i),
		.region_o  (region),
		.sub_adr_o (sub_adr),
		.csr_idx_o (csr_idx)
	);

	hb_csr_file hb_csr_file_i (
		.wb_clk_i       (wb_clk_i),
		.rst_i          (rst_i),
		.wbs_we_i       (wbs_we_i),
		.wbs_sel_i      (wbs_sel_i),
		.wbs_dat_i      (wbs_dat_i),
		.region_i       (region),
		.csr_idx_i      (csr_idx),
		.read_timeout_i (hb_rsp_i.read_timeout),
		.timing_o       (hb_timing_o),
		.csr_ack_o      (csr_ack),
		.csr_rdata_o    (csr_rdata)
	);

	hb_bus_response hb_bus_response_i (
		.wb_clk_i    (wb_clk_i),
		.rst_i       (rst_i),
		.wbs_we_i    (wbs_we_i),
		.wbs_sel_i   (wbs_sel_i),
		.wbs_dat_i   (wbs_dat_i),
		.region_i    (region),
		.sub_adr_i   (sub_adr),
		.csr_ack_i   (csr_ack),
		.csr_rdata_i (csr_rdata),
		.hb_rsp_i    (hb_rsp_i),
		.hb_req_o    (hb_req_o),
		.wbs_ack_o   (wbs_ack_o),
		.wbs_dat_o   (wbs_dat_o)
	);

endmodule
